/* verilog/ex_consts.svh */
// execute slice constants: data width, register address width, pipe and queue depths

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// data path
`define XLEN        32   // integer register width
`define REG_AW      5    // rd address bits, 32 gprs

// multiplier pipe
`define MULT_STAGES 3    // registered stages, first one holds the raw product

// write-back ordering
`define ORDER_DEPTH 4    // issued but not yet retired requests

`endif

/* verilog/ex_pkg.sv */
// execute slice types: operator and unit encodings, request and write-back structs

`include "ex_consts.svh"

package ex_pkg;

  // operator field of a decoded request
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_SRA  = 4'h7,
    OP_SLT  = 4'h8,
    OP_SLTU = 4'h9,
    OP_MUL  = 4'ha,   // low word of the product
    OP_MULH = 4'hb    // high word, both operands signed
  } alu_op_e;

  typedef enum logic {
    UNIT_ALU  = 1'b0,
    UNIT_MULT = 1'b1
  } unit_e;

  typedef struct packed {
    alu_op_e             op;
    logic [`XLEN-1:0]    operand_a;
    logic [`XLEN-1:0]    operand_b;
    logic [`REG_AW-1:0]  rd;
  } ex_req_t;   // 73 bits

  typedef struct packed {
    logic [`REG_AW-1:0]  rd;
    logic [`XLEN-1:0]    data;
  } wb_t;       // 37 bits

endpackage

/* verilog/pipe_slice.sv */
// pipe slice: one valid/ready register stage for any payload type

`timescale 1ns/1ns

module pipe_slice #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,

  // upstream side
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,

  // downstream side
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  logic valid_q;   // slot occupied
  T     data_q;

  // free slot, or the held item leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_q <= 1'b0;
    else if (in_ready_o)
      valid_q <= in_valid_i;   // refill or go empty
  end

  // payload only moves on an input transfer
  always_ff @(posedge clk_i)
  begin
    if (in_valid_i && in_ready_o)
      data_q <= in_data_i;
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

/* verilog/ex_issue.sv */
// issue: picks alu or multiplier for each request and logs the choice in the order queue

`timescale 1ns/1ns

module ex_issue import ex_pkg::*; (
  // from the input slice
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  ex_req_t req_i,

  // to the execution units
  output logic    alu_valid_o,
  input  logic    alu_ready_i,
  output logic    mult_valid_o,
  input  logic    mult_ready_i,
  output ex_req_t req_o,        // both units see the same request

  // push into the write-back order queue
  output logic    ord_valid_o,
  input  logic    ord_ready_i,
  output unit_e   ord_unit_o
);

  unit_e target;       // unit that will execute this request
  logic  is_mult;
  logic  unit_ready;   // ready of the chosen unit

  //////////////////////
  // unit decode
  //////////////////////

  assign is_mult    = (req_i.op == OP_MUL) || (req_i.op == OP_MULH);
  assign target     = is_mult ? UNIT_MULT : UNIT_ALU;
  assign unit_ready = is_mult ? mult_ready_i : alu_ready_i;

  //////////////////////
  // handshake fork
  //////////////////////

  // each side only fires when the other one can take it too
  assign alu_valid_o  = req_valid_i & ~is_mult & ord_ready_i;
  assign mult_valid_o = req_valid_i &  is_mult & ord_ready_i;
  assign ord_valid_o  = req_valid_i & unit_ready;

  assign req_ready_o  = unit_ready & ord_ready_i;   // unit and queue both take it

  assign req_o      = req_i;
  assign ord_unit_o = target;

endmodule

/* verilog/alu_unit.sv */
// alu unit: single-cycle integer operations into a one-deep result register

`timescale 1ns/1ns

`include "ex_consts.svh"

module alu_unit import ex_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  ex_req_t req_i,

  output logic    res_valid_o,
  input  logic    res_ready_i,
  output wb_t     res_o
);

  localparam int SHW = $clog2(`XLEN);   // shift amount bits

  logic [`XLEN-1:0] result;
  logic [SHW-1:0]   shamt;
  logic             lt_s;   // signed less-than
  logic             lt_u;   // unsigned less-than

  logic             valid_q;
  wb_t              res_q;

  assign shamt = req_i.operand_b[SHW-1:0];   // only the low bits count
  assign lt_s  = $signed(req_i.operand_a) < $signed(req_i.operand_b);
  assign lt_u  = req_i.operand_a < req_i.operand_b;

  //////////////////////
  // operation mux
  //////////////////////

  always_comb
  begin
    case (req_i.op)
      OP_ADD:  result = req_i.operand_a + req_i.operand_b;
      OP_SUB:  result = req_i.operand_a - req_i.operand_b;
      OP_AND:  result = req_i.operand_a & req_i.operand_b;
      OP_OR:   result = req_i.operand_a | req_i.operand_b;
      OP_XOR:  result = req_i.operand_a ^ req_i.operand_b;
      OP_SLL:  result = req_i.operand_a << shamt;
      OP_SRL:  result = req_i.operand_a >> shamt;
      OP_SRA:  result = $unsigned($signed(req_i.operand_a) >>> shamt);   // sign fill
      OP_SLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
      OP_SLTU: result = {{(`XLEN-1){1'b0}}, lt_u};
      default: result = '0;   // mul ops never get here
    endcase
  end

  //////////////////////
  // result slot
  //////////////////////

  assign in_ready_o = ~valid_q | res_ready_i;   // empty or draining

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_q <= 1'b0;
    else if (in_ready_o)
      valid_q <= in_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (in_valid_i && in_ready_o)
    begin
      res_q.rd   <= req_i.rd;
      res_q.data <= result;
    end
  end

  assign res_valid_o = valid_q;
  assign res_o       = res_q;

endmodule

/* verilog/mult_unit.sv */
// multiplier: fixed-depth 32x32 signed pipeline, low or high word out of the last stage

`timescale 1ns/1ns

`include "ex_consts.svh"

module mult_unit import ex_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  ex_req_t req_i,

  output logic    res_valid_o,
  input  logic    res_ready_i,
  output wb_t     res_o
);

  localparam int S = `MULT_STAGES;

  // what travels down the pipe
  typedef struct packed {
    logic [2*`XLEN-1:0] prod;
    logic               high;   // mulh, take the upper word
    logic [`REG_AW-1:0] rd;
  } mult_stage_t;

  logic signed [2*`XLEN-1:0] product;
  logic                      advance;   // whole pipe shifts this cycle

  logic [S-1:0]              valid_q;
  mult_stage_t               stage_q [S];

  // full signed product, low word is the same either way
  assign product = $signed(req_i.operand_a) * $signed(req_i.operand_b);

  // freeze everything while the tail result is held
  assign advance    = ~valid_q[S-1] | res_ready_i;
  assign in_ready_o = advance;

  //////////////////////
  // pipe registers
  //////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_q <= '0;
    else if (advance)
      valid_q <= {valid_q[S-2:0], in_valid_i};   // bubbles move too
  end

  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      stage_q[0].prod <= product;
      stage_q[0].high <= (req_i.op == OP_MULH);
      stage_q[0].rd   <= req_i.rd;
      for (int i = 1; i < S; i++)
        stage_q[i] <= stage_q[i-1];
    end
  end

  // word select at the tail
  always_comb
  begin
    res_o.rd   = stage_q[S-1].rd;
    res_o.data = stage_q[S-1].high ? stage_q[S-1].prod[2*`XLEN-1:`XLEN]
                                   : stage_q[S-1].prod[`XLEN-1:0];
  end

  assign res_valid_o = valid_q[S-1];

endmodule

/* verilog/wb_order.sv */
// write-back order: merges alu and multiplier results back into issue order

`timescale 1ns/1ns

`include "ex_consts.svh"

module wb_order import ex_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,

  // issue order pushes
  input  logic  ord_valid_i,
  output logic  ord_ready_o,
  input  unit_e ord_unit_i,

  // unit results
  input  logic  alu_valid_i,
  output logic  alu_ready_o,
  input  wb_t   alu_res_i,
  input  logic  mult_valid_i,
  output logic  mult_ready_o,
  input  wb_t   mult_res_i,

  // merged stream
  output logic  wb_valid_o,
  input  logic  wb_ready_i,
  output wb_t   wb_o
);

  localparam int D     = `ORDER_DEPTH;
  localparam int PTR_W = (D > 1) ? $clog2(D) : 1;
  localparam int CNT_W = $clog2(D + 1);

  unit_e            order_q [D];   // no reset, count_q says what is live
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  unit_e head;
  logic  empty;
  logic  push;
  logic  pop;

  assign head  = order_q[rd_ptr_q];
  assign empty = (count_q == '0);

  //////////////////////
  // head select
  //////////////////////

  // only the unit named at the head may pass, the other waits
  assign wb_valid_o   = ~empty & ((head == UNIT_ALU) ? alu_valid_i : mult_valid_i);
  assign wb_o         = (head == UNIT_ALU) ? alu_res_i : mult_res_i;
  assign alu_ready_o  = ~empty & (head == UNIT_ALU)  & wb_ready_i;
  assign mult_ready_o = ~empty & (head == UNIT_MULT) & wb_ready_i;

  assign pop         = wb_valid_o & wb_ready_i;
  assign ord_ready_o = (count_q != CNT_W'(D)) | pop;   // full queue can take one on a pop
  assign push        = ord_valid_i & ord_ready_o;

  //////////////////////
  // queue pointers
  //////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(D - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(D - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      order_q[wr_ptr_q] <= ord_unit_i;
  end

endmodule

/* verilog/ex_top.sv */
// execute slice top: input slice, issue, alu and multiplier, order merge, output slice

`timescale 1ns/1ns

module ex_top import ex_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,

  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  ex_req_t req_i,

  output logic    wb_valid_o,
  input  logic    wb_ready_i,
  output wb_t     wb_o
);

  // input slice to issue
  logic    iss_valid, iss_ready;
  ex_req_t iss_req;

  // issue to units
  logic    alu_valid, alu_ready, mult_valid, mult_ready;
  ex_req_t unit_req;

  // issue order push
  logic    ord_push_valid, ord_push_ready;
  unit_e   ord_push_unit;

  // unit results and merged stream
  logic    alu_res_valid, alu_res_ready, mult_res_valid, mult_res_ready;
  wb_t     alu_res, mult_res;
  logic    mrg_valid, mrg_ready;
  wb_t     mrg_res;

  pipe_slice #(.T(ex_req_t)) req_slice (
    .clk_i, .reset_i,
    .in_valid_i  (req_valid_i), .in_ready_o (req_ready_o), .in_data_i  (req_i),
    .out_valid_o (iss_valid),   .out_ready_i(iss_ready),   .out_data_o (iss_req)
  );

  ex_issue issue_i (
    .req_valid_i (iss_valid),      .req_ready_o (iss_ready),     .req_i (iss_req),
    .alu_valid_o (alu_valid),      .alu_ready_i (alu_ready),
    .mult_valid_o(mult_valid),     .mult_ready_i(mult_ready),    .req_o (unit_req),
    .ord_valid_o (ord_push_valid), .ord_ready_i (ord_push_ready), .ord_unit_o(ord_push_unit)
  );

  alu_unit alu_i (
    .clk_i, .reset_i,
    .in_valid_i (alu_valid),     .in_ready_o (alu_ready),     .req_i (unit_req),
    .res_valid_o(alu_res_valid), .res_ready_i(alu_res_ready), .res_o (alu_res)
  );

  mult_unit mult_i (
    .clk_i, .reset_i,
    .in_valid_i (mult_valid),     .in_ready_o (mult_ready),     .req_i (unit_req),
    .res_valid_o(mult_res_valid), .res_ready_i(mult_res_ready), .res_o (mult_res)
  );

  wb_order order_i (
    .clk_i, .reset_i,
    .ord_valid_i (ord_push_valid), .ord_ready_o (ord_push_ready), .ord_unit_i(ord_push_unit),
    .alu_valid_i (alu_res_valid),  .alu_ready_o (alu_res_ready),  .alu_res_i (alu_res),
    .mult_valid_i(mult_res_valid), .mult_ready_o(mult_res_ready), .mult_res_i(mult_res),
    .wb_valid_o  (mrg_valid),      .wb_ready_i  (mrg_ready),      .wb_o      (mrg_res)
  );

  pipe_slice #(.T(wb_t)) wb_slice (
    .clk_i, .reset_i,
    .in_valid_i  (mrg_valid),  .in_ready_o (mrg_ready),  .in_data_i  (mrg_res),
    .out_valid_o (wb_valid_o), .out_ready_i(wb_ready_i), .out_data_o (wb_o)
  );

endmodule

/* testbench/ex_properties.sv */
// execute slice properties: reset state and valid/ready rules on the outer ports

`timescale 1ns/1ns

module ex_properties import ex_pkg::*; (
  input logic clk_i,
  input logic reset_i,
  input logic req_valid_i,
  input logic req_ready_o,
  input logic wb_valid_o,
  input logic wb_ready_i,
  input wb_t  wb_o
);

  int unsigned fail_cnt = 0;   // failed property checks so far
  int unsigned stall_cnt;      // back-to-back stalled cycles, requests waiting

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stall_cnt <= 0;
    else if (wb_valid_o && !wb_ready_i && req_valid_i)
      stall_cnt <= stall_cnt + 1;
    else
      stall_cnt <= 0;   // any transfer or idle input restarts the count
  end

  // coming out of reset: nothing to write back, input open
  assert property (@(posedge clk_i) $past(reset_i) |-> !wb_valid_o && req_ready_o)
  else
  begin
    fail_cnt++;
    $error("write-back valid or request ready wrong right after reset");
  end

  // stalled result holds until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o))
  else
  begin
    fail_cnt++;
    $error("write-back result dropped or changed while stalled");
  end

  // long stall fills the pipe and closes the input
  assert property (@(posedge clk_i) disable iff (reset_i)
    (stall_cnt >= 7) && wb_valid_o && !wb_ready_i |-> !req_ready_o)
  else
  begin
    fail_cnt++;
    $error("request ready still high after a long output stall");
  end

endmodule

/* testbench/tb_ex_top.sv */
// execute slice testbench: random requests, reference model, in-order result scoreboard

`timescale 1ns/1ns

`include "ex_consts.svh"

module tb_ex_top import ex_pkg::*; ();

  localparam int N_ALU = 40;
  localparam int N_MUL = 40;
  localparam int N_MIX = 60;
  localparam int N_BP  = 60;
  localparam int LIMIT = (N_ALU + N_MUL + N_MIX + N_BP) * (`MULT_STAGES + 4) + 200;

  logic    clk_i, reset_i;
  logic    req_valid_i, req_ready_o;
  ex_req_t req_i;
  logic    wb_valid_o, wb_ready_i;
  wb_t     wb_o;

  int    seed = 32'hf789_0d71;
  int    cycle_cnt = 0;
  int    pass_cnt = 0;
  int    err_cnt = 0;
  int    total_fail;
  string test_name = "reset";
  wb_t   exp_q [$];    // expected results, oldest first
  wb_t   exp_res;

  ex_top dut (.*);

  bind ex_top ex_properties props (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////
  // reference model
  //////////////////////

  function automatic wb_t expected_wb(input ex_req_t r);
    logic [`XLEN-1:0]   a, b;
    logic [2*`XLEN-1:0] wide;   // sign-extended scratch
    int                 sh;
    wb_t                w;
    a    = r.operand_a;
    b    = r.operand_b;
    sh   = b[4:0];
    wide = '0;
    w.rd = r.rd;
    case (r.op)
      OP_ADD:  w.data = a + b;
      OP_SUB:  w.data = a + ~b + 1'b1;   // two's complement
      OP_AND:  w.data = a & b;
      OP_OR:   w.data = a | b;
      OP_XOR:  w.data = a ^ b;
      OP_SLL:  w.data = a << sh;
      OP_SRL:  w.data = a >> sh;
      OP_SRA:
      begin
        wide   = {{`XLEN{a[`XLEN-1]}}, a} >> sh;
        w.data = wide[`XLEN-1:0];
      end
      OP_SLT:  w.data = `XLEN'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));   // bias trick
      OP_SLTU: w.data = `XLEN'(a < b);
      default:
      begin
        // mul and mulh, low 64 bits of extended operands are the signed product
        wide   = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
        w.data = (r.op == OP_MULH) ? wide[2*`XLEN-1:`XLEN] : wide[`XLEN-1:0];
      end
    endcase
    return w;
  endfunction

  // mode 0 alu only, 1 multiplier only, 2 mixed
  function automatic ex_req_t random_req(input int mode);
    ex_req_t r;
    int      pick;
    pick = $unsigned($random(seed)) % 12;
    if (mode == 0)
      pick = pick % 10;
    else if (mode == 1)
      pick = 10 + pick % 2;
    r.op        = alu_op_e'(pick);
    r.operand_a = $random(seed);
    r.operand_b = $random(seed);
    r.rd        = $random(seed);
    return r;
  endfunction

  //////////////////////
  // stimulus
  //////////////////////

  task automatic run_test(input string name, input int n, input int mode,
                          input bit rnd_rdy, input int stall_at);
    int sent;
    int cyc;
    int errs_before;
    bit accepted;
    test_name   = name;
    errs_before = err_cnt;
    sent        = 0;
    cyc         = 0;
    req_i       = random_req(mode);
    req_valid_i = 1'b1;
    while (sent < n || exp_q.size() != 0)
    begin
      if (cyc >= stall_at && cyc < stall_at + 16)
        wb_ready_i = 1'b0;                     // forced stall window
      else if (rnd_rdy)
        wb_ready_i = ($random(seed) & 1) != 0;
      else
        wb_ready_i = 1'b1;
      @(negedge clk_i);
      accepted = req_valid_i && req_ready_o;   // transfer at the next edge
      if (accepted)
      begin
        exp_q.push_back(expected_wb(req_i));
        sent++;
      end
      @(posedge clk_i);
      #2;
      cyc++;
      if (accepted && sent < n)
        req_i = random_req(mode);
      else if (accepted)
        req_valid_i = 1'b0;
    end
    $display("%s: %0d requests, %0d errors", name, n, err_cnt - errs_before);
  endtask

  //////////////////////
  // scoreboard
  //////////////////////

  always @(negedge clk_i)
  begin
    if (!reset_i && wb_valid_o && wb_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        $display("%s: result for rd %0d arrived with no request pending", test_name, wb_o.rd);
        err_cnt++;
      end
      else
      begin
        exp_res = exp_q.pop_front();
        assert (wb_o == exp_res) pass_cnt++;
        else
        begin
          $display("ERR %s: expected rd=%0d data=%h, actual rd=%0d data=%h", test_name,
                   exp_res.rd, exp_res.data, wb_o.rd, wb_o.data);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt >= LIMIT)
    begin
      $display("timeout in %s: results stopped arriving after %0d cycles", test_name, cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial
  begin
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    wb_ready_i  = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    run_test("alu_only", N_ALU, 0, 1'b0, -100);
    run_test("mul_only", N_MUL, 1, 1'b0, -100);
    run_test("mixed_order", N_MIX, 2, 1'b0, -100);
    run_test("mixed_backpressure", N_BP, 2, 1'b1, 20);
    total_fail = err_cnt + dut.props.fail_cnt;
    $display("checks passed %0d, failed %0d", pass_cnt, total_fail);
    if (total_fail == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* sim.f */
+incdir+verilog
verilog/ex_pkg.sv
verilog/pipe_slice.sv
verilog/ex_issue.sv
verilog/alu_unit.sv
verilog/mult_unit.sv
verilog/wb_order.sv
verilog/ex_top.sv
testbench/ex_properties.sv
testbench/tb_ex_top.sv

/* run_sim.sh */
#!/bin/sh
# build the execute slice testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_top -f sim.f

# pass only if the pass line shows up in the output
./obj_dir/Vtb_ex_top +verilator+error+limit+100 | tee /dev/stderr | grep "TEST PASS" > /dev/null
echo "run_sim: simulation passed"
